//--- hw/flight_consts.svh
`ifndef FLIGHT_CONSTS_SVH
`define FLIGHT_CONSTS_SVH

// fixed-point values below are raw 12.4 numbers unless noted

// widths
`define RATE_BIT_WIDTH      16
`define REC_VAL_BIT_WIDTH   8

// stick*4 lands around this centre offset
`define MAPPING_SUBS        500

// throttle ceiling over a floor of zero
`define THROTTLE_MAX        250

// symmetric limit on yaw, pitch and roll rate targets
`define RATE_TARGET_MAX     100

// angle stage scale factors
`define YAW_SCALE_MULT      48
`define TILT_SCALE_MULT     32
// plain shift count rather than fixed point
`define SCALE_SHIFT         4

// proportional rate loop
`define RATE_GAIN           24
`define RATE_SHIFT          4

// symmetric limit on rate corrections
`define CORRECTION_MAX      200

// motor command range
`define MOTOR_VAL_MIN       0
`define MOTOR_VAL_MAX       400

`endif

//--- hw/flight_pkg.sv
`default_nettype none

`include "flight_consts.svh"

package flight_pkg;

	// 12.4 signed rate, angle and motor value
	typedef logic signed [`RATE_BIT_WIDTH-1:0] rate_t;
	// raw receiver stick value
	typedef logic [`REC_VAL_BIT_WIDTH-1:0] stick_t;
	// headroom for sums and products before limiting
	typedef logic signed [2*`RATE_BIT_WIDTH-1:0] wide_t;

	// saturate a wide intermediate into lo..hi, then drop to 16 bits
	function automatic rate_t clamp(input wide_t value, input wide_t lo, input wide_t hi);
		if (value > hi) begin
			return rate_t'(hi);
		end else if (value < lo) begin
			return rate_t'(lo);
		end
		return rate_t'(value);
	endfunction

endpackage

`default_nettype wire

//--- hw/angle_controller.sv
`default_nettype none

`include "flight_consts.svh"

module angle_controller (
	input  wire                     us_clk,
	input  wire                     resetn,
	input  wire                     start,
	input  wire flight_pkg::stick_t throttle_target,
	input  wire flight_pkg::stick_t yaw_target,
	input  wire flight_pkg::stick_t pitch_target,
	input  wire flight_pkg::stick_t roll_target,
	input  wire flight_pkg::rate_t  pitch_actual,
	input  wire flight_pkg::rate_t  roll_actual,
	output flight_pkg::rate_t       throttle_rate_out,
	output flight_pkg::rate_t       yaw_rate_out,
	output flight_pkg::rate_t       pitch_rate_out,
	output flight_pkg::rate_t       roll_rate_out,
	output flight_pkg::rate_t       pitch_angle_error,
	output flight_pkg::rate_t       roll_angle_error,
	output logic                    active,
	output logic                    complete
);
	import flight_pkg::*;

	// one-hot states
	localparam logic [4:0] ST_WAITING  = 5'b00001;
	localparam logic [4:0] ST_MAPPING  = 5'b00010;
	localparam logic [4:0] ST_SCALING  = 5'b00100;
	localparam logic [4:0] ST_LIMITING = 5'b01000;
	localparam logic [4:0] ST_COMPLETE = 5'b10000;

	logic [4:0] state;
	logic [4:0] next_state;
	logic       start_flag;
	logic       leave_wait;

	// inputs captured on leaving waiting
	stick_t lat_throttle;
	stick_t lat_yaw;
	stick_t lat_pitch;
	stick_t lat_roll;
	rate_t  lat_pitch_actual;
	rate_t  lat_roll_actual;

	wide_t mapped_throttle;
	wide_t mapped_yaw;
	wide_t mapped_pitch;
	wide_t mapped_roll;
	wide_t scaled_yaw;
	wide_t scaled_pitch;
	wide_t scaled_roll;

	assign leave_wait = (state == ST_WAITING) && start_flag;

	// a start during a run stays pending until we are back in waiting
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_flag <= 1'b0;
		end else if (start) begin
			start_flag <= 1'b1;
		end else if (state == ST_WAITING) begin
			start_flag <= 1'b0;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= ST_WAITING;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			ST_WAITING:  next_state = leave_wait ? ST_MAPPING : ST_WAITING;
			ST_MAPPING:  next_state = ST_SCALING;
			ST_SCALING:  next_state = ST_LIMITING;
			ST_LIMITING: next_state = ST_COMPLETE;
			ST_COMPLETE: next_state = ST_WAITING;
			default:     next_state = ST_WAITING;
		endcase
	end

	always_ff @(posedge us_clk) begin
		if (leave_wait) begin
			lat_throttle     <= throttle_target;
			lat_yaw          <= yaw_target;
			lat_pitch        <= pitch_target;
			lat_roll         <= roll_target;
			lat_pitch_actual <= pitch_actual;
			lat_roll_actual  <= roll_actual;
		end
	end

	always_ff @(posedge us_clk) begin
		if (state == ST_MAPPING) begin
			// throttle stick to 12.4 and the others centred around zero
			mapped_throttle <= wide_t'(lat_throttle) * 16;
			mapped_yaw      <= wide_t'(lat_yaw) * 4 - `MAPPING_SUBS;
			mapped_pitch    <= wide_t'(lat_pitch) * 4 - `MAPPING_SUBS - wide_t'(lat_pitch_actual);
			// IMU reports roll with the opposite sign
			mapped_roll     <= wide_t'(lat_roll) * 4 - `MAPPING_SUBS + wide_t'(lat_roll_actual);
		end
	end

	always_ff @(posedge us_clk) begin
		if (state == ST_SCALING) begin
			scaled_yaw   <= (mapped_yaw * `YAW_SCALE_MULT) >>> `SCALE_SHIFT;
			scaled_pitch <= (mapped_pitch * `TILT_SCALE_MULT) >>> `SCALE_SHIFT;
			scaled_roll  <= (mapped_roll * `TILT_SCALE_MULT) >>> `SCALE_SHIFT;
		end
	end

	// outputs only move here, so they hold between completes
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			throttle_rate_out <= '0;
			yaw_rate_out      <= '0;
			pitch_rate_out    <= '0;
			roll_rate_out     <= '0;
			pitch_angle_error <= '0;
			roll_angle_error  <= '0;
		end else if (state == ST_LIMITING) begin
			throttle_rate_out <= clamp(mapped_throttle, `MOTOR_VAL_MIN, `THROTTLE_MAX);
			yaw_rate_out      <= clamp(scaled_yaw, -(`RATE_TARGET_MAX), `RATE_TARGET_MAX);
			pitch_rate_out    <= clamp(scaled_pitch, -(`RATE_TARGET_MAX), `RATE_TARGET_MAX);
			roll_rate_out     <= clamp(scaled_roll, -(`RATE_TARGET_MAX), `RATE_TARGET_MAX);
			pitch_angle_error <= rate_t'(mapped_pitch);
			roll_angle_error  <= rate_t'(mapped_roll);
		end
	end

	// pending start counts as busy so the chain shows no gap
	assign active   = start_flag || (state != ST_WAITING);
	assign complete = (state == ST_COMPLETE);

endmodule

`default_nettype wire

//--- hw/rate_controller.sv
`default_nettype none

`include "flight_consts.svh"

module rate_controller (
	input  wire                    us_clk,
	input  wire                    resetn,
	input  wire                    start,
	input  wire flight_pkg::rate_t throttle_in,
	input  wire flight_pkg::rate_t yaw_target,
	input  wire flight_pkg::rate_t pitch_target,
	input  wire flight_pkg::rate_t roll_target,
	input  wire flight_pkg::rate_t yaw_gyro,
	input  wire flight_pkg::rate_t pitch_gyro,
	input  wire flight_pkg::rate_t roll_gyro,
	output flight_pkg::rate_t      throttle_out,
	output flight_pkg::rate_t      yaw_corr,
	output flight_pkg::rate_t      pitch_corr,
	output flight_pkg::rate_t      roll_corr,
	output logic                   active,
	output logic                   complete
);
	import flight_pkg::*;

	localparam logic [3:0] ST_WAITING  = 4'b0001;
	localparam logic [3:0] ST_ERROR    = 4'b0010;
	localparam logic [3:0] ST_PRODUCT  = 4'b0100;
	localparam logic [3:0] ST_COMPLETE = 4'b1000;

	logic [3:0] state;
	logic [3:0] next_state;
	logic       start_flag;
	logic       leave_wait;

	rate_t lat_throttle;
	rate_t lat_yaw_target;
	rate_t lat_pitch_target;
	rate_t lat_roll_target;
	rate_t lat_yaw_gyro;
	rate_t lat_pitch_gyro;
	rate_t lat_roll_gyro;

	wide_t yaw_err;
	wide_t pitch_err;
	wide_t roll_err;

	assign leave_wait = (state == ST_WAITING) && start_flag;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_flag <= 1'b0;
		end else if (start) begin
			start_flag <= 1'b1;
		end else if (state == ST_WAITING) begin
			start_flag <= 1'b0;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= ST_WAITING;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			ST_WAITING:  next_state = leave_wait ? ST_ERROR : ST_WAITING;
			ST_ERROR:    next_state = ST_PRODUCT;
			ST_PRODUCT:  next_state = ST_COMPLETE;
			ST_COMPLETE: next_state = ST_WAITING;
			default:     next_state = ST_WAITING;
		endcase
	end

	always_ff @(posedge us_clk) begin
		if (leave_wait) begin
			lat_throttle     <= throttle_in;
			lat_yaw_target   <= yaw_target;
			lat_pitch_target <= pitch_target;
			lat_roll_target  <= roll_target;
			lat_yaw_gyro     <= yaw_gyro;
			lat_pitch_gyro   <= pitch_gyro;
			lat_roll_gyro    <= roll_gyro;
		end
		// rate error per axis
		if (state == ST_ERROR) begin
			yaw_err   <= wide_t'(lat_yaw_target) - wide_t'(lat_yaw_gyro);
			pitch_err <= wide_t'(lat_pitch_target) - wide_t'(lat_pitch_gyro);
			roll_err  <= wide_t'(lat_roll_target) - wide_t'(lat_roll_gyro);
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			throttle_out <= '0;
			yaw_corr     <= '0;
			pitch_corr   <= '0;
			roll_corr    <= '0;
		end else if (state == ST_PRODUCT) begin
			// throttle rides along so it lines up with the corrections
			throttle_out <= lat_throttle;
			yaw_corr     <= clamp((yaw_err * `RATE_GAIN) >>> `RATE_SHIFT,
				-(`CORRECTION_MAX), `CORRECTION_MAX);
			pitch_corr   <= clamp((pitch_err * `RATE_GAIN) >>> `RATE_SHIFT,
				-(`CORRECTION_MAX), `CORRECTION_MAX);
			roll_corr    <= clamp((roll_err * `RATE_GAIN) >>> `RATE_SHIFT,
				-(`CORRECTION_MAX), `CORRECTION_MAX);
		end
	end

	assign active   = start_flag || (state != ST_WAITING);
	assign complete = (state == ST_COMPLETE);

endmodule

`default_nettype wire

//--- hw/motor_mixer.sv
`default_nettype none

`include "flight_consts.svh"

module motor_mixer (
	input  wire                    us_clk,
	input  wire                    resetn,
	input  wire                    start,
	input  wire flight_pkg::rate_t throttle_in,
	input  wire flight_pkg::rate_t yaw_corr,
	input  wire flight_pkg::rate_t pitch_corr,
	input  wire flight_pkg::rate_t roll_corr,
	output flight_pkg::rate_t      motor_0,
	output flight_pkg::rate_t      motor_1,
	output flight_pkg::rate_t      motor_2,
	output flight_pkg::rate_t      motor_3,
	output logic                   active,
	output logic                   complete
);
	import flight_pkg::*;

	localparam logic [2:0] ST_WAITING  = 3'b001;
	localparam logic [2:0] ST_SUM      = 3'b010;
	localparam logic [2:0] ST_COMPLETE = 3'b100;

	logic [2:0] state;
	logic [2:0] next_state;
	logic       start_flag;
	logic       leave_wait;

	wide_t lat_throttle;
	wide_t lat_yaw;
	wide_t lat_pitch;
	wide_t lat_roll;

	wide_t sum_0;
	wide_t sum_1;
	wide_t sum_2;
	wide_t sum_3;

	assign leave_wait = (state == ST_WAITING) && start_flag;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_flag <= 1'b0;
		end else if (start) begin
			start_flag <= 1'b1;
		end else if (state == ST_WAITING) begin
			start_flag <= 1'b0;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= ST_WAITING;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			ST_WAITING:  next_state = leave_wait ? ST_SUM : ST_WAITING;
			ST_SUM:      next_state = ST_COMPLETE;
			ST_COMPLETE: next_state = ST_WAITING;
			default:     next_state = ST_WAITING;
		endcase
	end

	// widened on capture so the sums cannot wrap
	always_ff @(posedge us_clk) begin
		if (leave_wait) begin
			lat_throttle <= wide_t'(throttle_in);
			lat_yaw      <= wide_t'(yaw_corr);
			lat_pitch    <= wide_t'(pitch_corr);
			lat_roll     <= wide_t'(roll_corr);
		end
	end

	// diagonal pairs of the X-frame share a yaw sign
	assign sum_0 = lat_throttle + lat_pitch + lat_roll - lat_yaw;
	assign sum_1 = lat_throttle + lat_pitch - lat_roll + lat_yaw;
	assign sum_2 = lat_throttle - lat_pitch - lat_roll - lat_yaw;
	assign sum_3 = lat_throttle - lat_pitch + lat_roll + lat_yaw;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motor_0 <= '0;
			motor_1 <= '0;
			motor_2 <= '0;
			motor_3 <= '0;
		end else if (state == ST_SUM) begin
			motor_0 <= clamp(sum_0, `MOTOR_VAL_MIN, `MOTOR_VAL_MAX);
			motor_1 <= clamp(sum_1, `MOTOR_VAL_MIN, `MOTOR_VAL_MAX);
			motor_2 <= clamp(sum_2, `MOTOR_VAL_MIN, `MOTOR_VAL_MAX);
			motor_3 <= clamp(sum_3, `MOTOR_VAL_MIN, `MOTOR_VAL_MAX);
		end
	end

	assign active   = start_flag || (state != ST_WAITING);
	assign complete = (state == ST_COMPLETE);

endmodule

`default_nettype wire

//--- hw/flight_core.sv
`default_nettype none

module flight_core (
	input  wire                     us_clk,
	input  wire                     resetn,
	input  wire                     start,
	input  wire flight_pkg::stick_t throttle_target,
	input  wire flight_pkg::stick_t yaw_target,
	input  wire flight_pkg::stick_t pitch_target,
	input  wire flight_pkg::stick_t roll_target,
	input  wire flight_pkg::rate_t  pitch_actual,
	input  wire flight_pkg::rate_t  roll_actual,
	input  wire flight_pkg::rate_t  yaw_gyro,
	input  wire flight_pkg::rate_t  pitch_gyro,
	input  wire flight_pkg::rate_t  roll_gyro,
	output flight_pkg::rate_t       motor_0,
	output flight_pkg::rate_t       motor_1,
	output flight_pkg::rate_t       motor_2,
	output flight_pkg::rate_t       motor_3,
	output flight_pkg::rate_t       pitch_angle_error,
	output flight_pkg::rate_t       roll_angle_error,
	output logic                    busy,
	output logic                    done
);
	import flight_pkg::*;

	// angle stage to rate stage
	rate_t throttle_rate;
	rate_t yaw_rate;
	rate_t pitch_rate;
	rate_t roll_rate;
	// rate stage to mixer
	rate_t throttle_cmd;
	rate_t yaw_corr;
	rate_t pitch_corr;
	rate_t roll_corr;

	logic angle_active;
	logic angle_complete;
	logic rate_active;
	logic rate_complete;
	logic mixer_active;

	angle_controller u_angle (
		.us_clk, .resetn, .start,
		.throttle_target, .yaw_target, .pitch_target, .roll_target,
		.pitch_actual, .roll_actual,
		.throttle_rate_out(throttle_rate), .yaw_rate_out(yaw_rate),
		.pitch_rate_out(pitch_rate), .roll_rate_out(roll_rate),
		.pitch_angle_error, .roll_angle_error,
		.active(angle_active), .complete(angle_complete)
	);

	rate_controller u_rate (
		.us_clk, .resetn, .start(angle_complete),
		.throttle_in(throttle_rate), .yaw_target(yaw_rate),
		.pitch_target(pitch_rate), .roll_target(roll_rate),
		.yaw_gyro, .pitch_gyro, .roll_gyro,
		.throttle_out(throttle_cmd), .yaw_corr, .pitch_corr, .roll_corr,
		.active(rate_active), .complete(rate_complete)
	);

	// mixer complete is the end of the chain
	motor_mixer u_mixer (
		.us_clk, .resetn, .start(rate_complete),
		.throttle_in(throttle_cmd), .yaw_corr, .pitch_corr, .roll_corr,
		.motor_0, .motor_1, .motor_2, .motor_3,
		.active(mixer_active), .complete(done)
	);

	assign busy = angle_active || rate_active || mixer_active;

endmodule

`default_nettype wire

//--- testbench/flight_core_tb.sv
`default_nettype none

`include "flight_consts.svh"

module flight_core_tb;
	import flight_pkg::*;

	typedef struct packed {
		rate_t motor_0;
		rate_t motor_1;
		rate_t motor_2;
		rate_t motor_3;
		rate_t pitch_err;
		rate_t roll_err;
	} expected_t;

	logic   us_clk;
	logic   resetn;
	logic   start;
	stick_t throttle_target;
	stick_t yaw_target;
	stick_t pitch_target;
	stick_t roll_target;
	rate_t  pitch_actual;
	rate_t  roll_actual;
	rate_t  yaw_gyro;
	rate_t  pitch_gyro;
	rate_t  roll_gyro;
	rate_t  motor_0;
	rate_t  motor_1;
	rate_t  motor_2;
	rate_t  motor_3;
	rate_t  pitch_angle_error;
	rate_t  roll_angle_error;
	logic   busy;
	logic   done;

	integer    seed;
	integer    errors;
	integer    checks;
	integer    done_count;
	integer    tests_run;
	integer    errors_mark;
	integer    base;
	integer    i;
	expected_t expected_q[$];

	flight_core DUT (
		.us_clk(us_clk), .resetn(resetn), .start(start),
		.throttle_target(throttle_target), .yaw_target(yaw_target),
		.pitch_target(pitch_target), .roll_target(roll_target),
		.pitch_actual(pitch_actual), .roll_actual(roll_actual),
		.yaw_gyro(yaw_gyro), .pitch_gyro(pitch_gyro), .roll_gyro(roll_gyro),
		.motor_0(motor_0), .motor_1(motor_1), .motor_2(motor_2), .motor_3(motor_3),
		.pitch_angle_error(pitch_angle_error), .roll_angle_error(roll_angle_error),
		.busy(busy), .done(done)
	);

	initial begin
		us_clk = 1'b0;
		forever #4 us_clk = ~us_clk;
	end

	function automatic integer saturate(input integer value, input integer lo, input integer hi);
		if (value > hi) begin
			return hi;
		end else if (value < lo) begin
			return lo;
		end
		return value;
	endfunction

	// whole chain in integer math from sticks to motors
	function automatic expected_t flight_ref(input stick_t thr, input stick_t yaw,
		input stick_t pit, input stick_t rol, input rate_t pa, input rate_t ra,
		input rate_t yg, input rate_t pg, input rate_t rg);
		integer    m_yaw;
		integer    m_pit;
		integer    m_rol;
		integer    t_thr;
		integer    t_yaw;
		integer    t_pit;
		integer    t_rol;
		integer    c_yaw;
		integer    c_pit;
		integer    c_rol;
		expected_t res;
		m_yaw = integer'(yaw) * 4 - `MAPPING_SUBS;
		m_pit = integer'(pit) * 4 - `MAPPING_SUBS - integer'(pa);
		m_rol = integer'(rol) * 4 - `MAPPING_SUBS + integer'(ra);
		t_thr = saturate(integer'(thr) * 16, 0, `THROTTLE_MAX);
		t_yaw = saturate((m_yaw * `YAW_SCALE_MULT) >>> `SCALE_SHIFT,
			-`RATE_TARGET_MAX, `RATE_TARGET_MAX);
		t_pit = saturate((m_pit * `TILT_SCALE_MULT) >>> `SCALE_SHIFT,
			-`RATE_TARGET_MAX, `RATE_TARGET_MAX);
		t_rol = saturate((m_rol * `TILT_SCALE_MULT) >>> `SCALE_SHIFT,
			-`RATE_TARGET_MAX, `RATE_TARGET_MAX);
		c_yaw = saturate(((t_yaw - integer'(yg)) * `RATE_GAIN) >>> `RATE_SHIFT,
			-`CORRECTION_MAX, `CORRECTION_MAX);
		c_pit = saturate(((t_pit - integer'(pg)) * `RATE_GAIN) >>> `RATE_SHIFT,
			-`CORRECTION_MAX, `CORRECTION_MAX);
		c_rol = saturate(((t_rol - integer'(rg)) * `RATE_GAIN) >>> `RATE_SHIFT,
			-`CORRECTION_MAX, `CORRECTION_MAX);
		res.motor_0 = rate_t'(saturate(t_thr + c_pit + c_rol - c_yaw, 0, `MOTOR_VAL_MAX));
		res.motor_1 = rate_t'(saturate(t_thr + c_pit - c_rol + c_yaw, 0, `MOTOR_VAL_MAX));
		res.motor_2 = rate_t'(saturate(t_thr - c_pit - c_rol - c_yaw, 0, `MOTOR_VAL_MAX));
		res.motor_3 = rate_t'(saturate(t_thr - c_pit + c_rol + c_yaw, 0, `MOTOR_VAL_MAX));
		// angle errors are the mapped values cut to 16 bits
		res.pitch_err = rate_t'(m_pit);
		res.roll_err = rate_t'(m_rol);
		return res;
	endfunction

	task automatic check_value(input string name, input integer expected, input integer actual);
		checks = checks + 1;
		if (expected !== actual) begin
			$display("Mismatch at time %0t: %s expected %0d actual %0d",
				$time, name, expected, actual);
			errors = errors + 1;
		end
	endtask

	task automatic step();
		@(posedge us_clk);
		#1;
	endtask

	task automatic end_test(input string name);
		tests_run = tests_run + 1;
		$display("test %0d (%s) finished with %0d errors", tests_run, name, errors - errors_mark);
		errors_mark = errors;
	endtask

	task automatic drive_inputs(input stick_t thr, input stick_t yaw, input stick_t pit,
		input stick_t rol, input rate_t pa, input rate_t ra, input rate_t yg,
		input rate_t pg, input rate_t rg);
		throttle_target = thr;
		yaw_target = yaw;
		pitch_target = pit;
		roll_target = rol;
		pitch_actual = pa;
		roll_actual = ra;
		yaw_gyro = yg;
		pitch_gyro = pg;
		roll_gyro = rg;
	endtask

	task automatic expect_current();
		expected_q.push_back(flight_ref(throttle_target, yaw_target, pitch_target, roll_target,
			pitch_actual, roll_actual, yaw_gyro, pitch_gyro, roll_gyro));
	endtask

	task automatic wait_done(input integer target);
		integer waited;
		waited = 0;
		while (done_count < target && waited < 100) begin
			step();
			waited = waited + 1;
		end
		if (done_count < target) begin
			$display("timeout at time %0t: done pulse %0d never came", $time, target);
			errors = errors + 1;
		end
	endtask

	task automatic run_sample();
		base = done_count;
		expect_current();
		start = 1'b1;
		step();
		start = 1'b0;
		wait_done(base + 1);
	endtask

	// compares every done pulse against the oldest queued result
	always @(posedge us_clk) begin : compare
		expected_t exp_val;
		if (resetn && done) begin
			done_count = done_count + 1;
			if (expected_q.size() == 0) begin
				$display("done pulse at time %0t without any expected result", $time);
				errors = errors + 1;
			end else begin
				exp_val = expected_q.pop_front();
				check_value("motor_0", exp_val.motor_0, motor_0);
				check_value("motor_1", exp_val.motor_1, motor_1);
				check_value("motor_2", exp_val.motor_2, motor_2);
				check_value("motor_3", exp_val.motor_3, motor_3);
				check_value("pitch_angle_error", exp_val.pitch_err, pitch_angle_error);
				check_value("roll_angle_error", exp_val.roll_err, roll_angle_error);
			end
		end
	end

	initial begin
		seed = 32'h62a8_046b;
		errors = 0;
		checks = 0;
		done_count = 0;
		tests_run = 0;
		errors_mark = 0;
		resetn = 1'b0;
		start = 1'b0;
		drive_inputs(0, 0, 0, 0, 0, 0, 0, 0, 0);
		repeat (16) @(posedge us_clk);
		#1 resetn = 1'b1;
		step();

		check_value("busy", 0, busy);
		check_value("done", 0, done);
		check_value("motor_0", 0, motor_0);
		check_value("motor_1", 0, motor_1);
		check_value("motor_2", 0, motor_2);
		check_value("motor_3", 0, motor_3);
		check_value("pitch_angle_error", 0, pitch_angle_error);
		check_value("roll_angle_error", 0, roll_angle_error);
		end_test("reset values");

		drive_inputs(125, 125, 125, 125, 0, 0, 0, 0, 0);
		run_sample();
		end_test("centred sticks");

		for (i = 0; i < 50; i = i + 1) begin
			drive_inputs($random(seed), $random(seed), $random(seed), $random(seed),
				$random(seed) % 200, $random(seed) % 200, $random(seed) % 300,
				$random(seed) % 300, $random(seed) % 300);
			run_sample();
		end
		end_test("random inputs");

		// corners that push targets, corrections and motors into their limits
		drive_inputs(255, 255, 255, 255, -3000, 3000, -4000, -4000, -4000);
		run_sample();
		drive_inputs(0, 0, 0, 0, 3000, -3000, 4000, 4000, 4000);
		run_sample();
		drive_inputs(255, 0, 255, 0, 32000, -32000, 30000, -30000, 0);
		run_sample();
		drive_inputs(40, 255, 0, 255, -32000, 32000, -30000, 30000, 12000);
		run_sample();
		end_test("limits");

		drive_inputs(180, 90, 160, 70, 25, -40, 15, -20, 35);
		base = done_count;
		expect_current();
		expect_current();
		start = 1'b1;
		step();
		start = 1'b0;
		step();
		step();
		start = 1'b1;
		step();
		start = 1'b0;
		wait_done(base + 2);
		repeat (30) step();
		check_value("done pulses", base + 2, done_count);
		end_test("start while busy");

		drive_inputs(100, 140, 110, 150, -10, 12, 5, -8, 3);
		check_value("busy", 0, busy);
		base = done_count;
		expect_current();
		start = 1'b1;
		step();
		start = 1'b0;
		for (i = 1; i < 12; i = i + 1) begin
			check_value("busy", 1, busy);
			check_value("done", 0, done);
			step();
		end
		check_value("busy", 1, busy);
		check_value("done", 1, done);
		wait_done(base + 1);
		end_test("start to done latency");

		if (expected_q.size() != 0) begin
			$display("%0d expected results never arrived", expected_q.size());
			errors = errors + 1;
		end
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hw
hw/flight_pkg.sv
hw/angle_controller.sv
hw/rate_controller.sv
hw/motor_mixer.sv
hw/flight_core.sv
testbench/flight_core_tb.sv
